//--- sim.f
+incdir+rtl
rtl/net_stream_pkg.sv
rtl/net_proto_pkg.sv
rtl/net_addr_config.sv
rtl/rx_classifier.sv
rtl/tx_merger.sv
rtl/net_stats.sv
rtl/net_front.sv
dv/net_front_tb.sv

//--- Bender.yml
package:
  name: net_front

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/net_stream_pkg.sv
      - rtl/net_proto_pkg.sv
      - rtl/net_addr_config.sv
      - rtl/rx_classifier.sv
      - rtl/tx_merger.sv
      - rtl/net_stats.sv
      - rtl/net_front.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - dv/net_front_tb.sv

//--- dv/net_front_tb.sv
/*
 * net_front testbench
 * table driven rx routing and tx merge with random sink stalls,
 * plus address config, counter and stall flag checks
 */
`timescale 1ns/1ps
`include "net_macros.svh"

module net_front_tb;
  import net_proto_pkg::*;

  localparam int N_RX = 8;
  localparam int N_TX = 6;

  // rx table: ethertype, ip protocol, beats, expected class
  logic [15:0] rx_eth [N_RX] = '{`NET_ETH_ARP, `NET_ETH_IPV4, `NET_ETH_IPV4, `NET_ETH_IPV4,
                                 16'h86DD, `NET_ETH_IPV4, `NET_ETH_ARP, `NET_ETH_IPV4};
  logic [7:0]  rx_prot [N_RX] = '{8'd0, 8'd1, 8'd6, 8'd17, 8'd6, 8'd6, 8'd6, 8'd1};
  int          rx_len [N_RX] = '{3, 2, 4, 2, 3, 1, 2, 3};
  proto_e      rx_cls [N_RX] = '{PROTO_ARP, PROTO_ICMP, PROTO_TCP, PROTO_DROP,
                                 PROTO_DROP, PROTO_TCP, PROTO_ARP, PROTO_ICMP};
  // tx table: source is tcp, beats
  bit          tx_tcp [N_TX] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0};
  int          tx_len [N_TX] = '{2, 3, 1, 2, 1, 3};

  logic        user_clk, net_aresetn;
  logic [31:0] set_ip_addr_data, local_ip_address, default_gateway;
  logic [7:0]  set_board_number_data;
  logic [47:0] local_mac_address;
  logic        rx_valid, rx_last, rx_ready, rx_out_last;
  logic [63:0] rx_data, rx_out_data;
  logic [7:0]  rx_keep, rx_out_keep;
  logic        arp_rx_valid, arp_rx_ready, icmp_rx_valid, icmp_rx_ready;
  logic        tcp_rx_valid, tcp_rx_ready;
  logic        arp_tx_valid, arp_tx_last, arp_tx_ready;
  logic        tcp_tx_valid, tcp_tx_last, tcp_tx_ready;
  logic [63:0] arp_tx_data, tcp_tx_data, net_tx_data;
  logic [7:0]  arp_tx_keep, tcp_tx_keep, net_tx_keep;
  logic        net_tx_valid, net_tx_ready, net_tx_last, rx_stall;
  logic [31:0] rx_word_count, rx_pkt_count, tx_word_count, tx_pkt_count;
  logic [31:0] tcp_rx_pkt_count, drop_pkt_count;

  integer      seed = 32'hb22060a8;
  int          errors = 0;
  int          checks = 0;
  int          err0;
  bit          rand_ready = 1'b0;  // sinks toggle randomly when set
  logic [63:0] rx_pay [32];
  logic [63:0] tx_pay [32];        // arp from 0, tcp from 16
  logic [74:0] rx_exp_q [$];       // {class, keep, last, data}
  logic [72:0] arp_exp_q [$];      // {keep, last, data}
  logic [72:0] tcp_exp_q [$];
  logic [74:0] rx_e;
  logic [72:0] tx_e;
  bit          tx_busy = 1'b0;     // net_tx inside a packet
  bit          tx_cur_tcp, tx_src_tcp, tx_have;

  net_front DUT (.*);

  initial begin
    user_clk = 1'b0;
    forever #4 user_clk = ~user_clk;
  end

  function automatic int total_beats();
    int n;
    n = 1;  // the stall packet
    foreach (rx_len[i]) n += rx_len[i];
    foreach (tx_len[i]) n += tx_len[i];
    return n;
  endfunction

  // ready the router should present for a class
  function automatic logic expected_ready(proto_e c);
    case (c)
      PROTO_ARP:  return arp_rx_ready;
      PROTO_ICMP: return icmp_rx_ready;
      PROTO_TCP:  return tcp_rx_ready;
      default:    return 1'b1;
    endcase
  endfunction

  function automatic logic [2:0] expected_valids(proto_e c);  // {arp, icmp, tcp}
    case (c)
      PROTO_ARP:  return 3'b100;
      PROTO_ICMP: return 3'b010;
      PROTO_TCP:  return 3'b001;
      default:    return 3'b000;
    endcase
  endfunction

  task automatic compare(string name, logic [63:0] got, logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED %0t ns %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic report(string name);
    if (errors == err0) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, errors - err0);
    err0 = errors;
  endtask

  // hold the rx beat until it transfers, resume 1 ns after the edge
  task automatic wait_rx_xfer();
    bit fire;
    do begin
      @(negedge user_clk);
      fire = rx_ready;
      @(posedge user_clk);
      #1;
    end while (!fire);
  endtask

  task automatic send_rx(int p, int base);
    logic [63:0] d;
    for (int b = 0; b < rx_len[p]; b++) begin
      d = rx_pay[base + b];
      if (b == 0) d[23:0] = {rx_prot[p], rx_eth[p]};  // header fields
      rx_valid = 1'b1;
      rx_data  = d;
      rx_last  = (b == rx_len[p] - 1);
      rx_keep  = rx_last ? 8'h3F : 8'hFF;
      rx_exp_q.push_back({rx_cls[p], rx_keep, rx_last, d});
      wait_rx_xfer();
    end
    rx_valid = 1'b0;
  endtask

  task automatic send_tx(bit tcp, int len, int base);
    logic [63:0] d;
    logic [7:0]  k;
    logic        l;
    bit          fire;
    for (int b = 0; b < len; b++) begin
      d = {(tcp ? 8'hC0 : 8'hA0), tx_pay[base + b][55:0]};  // top byte tags source
      l = (b == len - 1);
      k = l ? 8'h0F : 8'hFF;
      if (tcp) begin
        {tcp_tx_valid, tcp_tx_data, tcp_tx_keep, tcp_tx_last} = {1'b1, d, k, l};
        tcp_exp_q.push_back({k, l, d});
      end else begin
        {arp_tx_valid, arp_tx_data, arp_tx_keep, arp_tx_last} = {1'b1, d, k, l};
        arp_exp_q.push_back({k, l, d});
      end
      do begin
        @(negedge user_clk);
        fire = tcp ? tcp_tx_ready : arp_tx_ready;
        @(posedge user_clk);
        #1;
      end while (!fire);
    end
    if (tcp) tcp_tx_valid = 1'b0;
    else arp_tx_valid = 1'b0;
  endtask

  task automatic send_source(bit tcp);  // this source's table rows in order
    int base;
    base = tcp ? 16 : 0;
    for (int p = 0; p < N_TX; p++) begin
      if (tx_tcp[p] == tcp) begin
        send_tx(tcp, tx_len[p], base);
        base += tx_len[p];
      end
    end
  endtask

  always @(posedge user_clk) begin
    #1;
    if (rand_ready) begin
      arp_rx_ready  = ($random(seed) & 3) != 0;  // low about one cycle in four
      icmp_rx_ready = ($random(seed) & 3) != 0;
      tcp_rx_ready  = ($random(seed) & 3) != 0;
      net_tx_ready  = ($random(seed) & 3) != 0;
    end
  end

  // rx monitor, mid cycle while everything is settled
  always @(negedge user_clk) begin
    if (net_aresetn && rx_valid && rx_exp_q.size() > 0) begin
      rx_e = rx_exp_q[0];
      compare("rx_ready", rx_ready, expected_ready(proto_e'(rx_e[74:73])));
      compare("rx valids", {arp_rx_valid, icmp_rx_valid, tcp_rx_valid},
              expected_valids(proto_e'(rx_e[74:73])));
      if (rx_ready) begin
        void'(rx_exp_q.pop_front());
        if (proto_e'(rx_e[74:73]) != PROTO_DROP) begin
          compare("rx_out_data", rx_out_data, rx_e[63:0]);
          compare("rx_out_keep", rx_out_keep, rx_e[72:65]);
          compare("rx_out_last", rx_out_last, rx_e[64]);
        end
      end
    end else if (net_aresetn) begin
      compare("rx valids", {arp_rx_valid, icmp_rx_valid, tcp_rx_valid}, 3'b000);
    end
  end

  // tx monitor, one source per packet
  always @(negedge user_clk) begin
    if (net_aresetn && net_tx_valid && net_tx_ready) begin
      tx_src_tcp = (net_tx_data[63:56] == 8'hC0);
      checks++;
      assert (!tx_busy || tx_src_tcp == tx_cur_tcp) else begin
        errors++;
        $display("net_tx switched source inside a packet at %0t ns", $time);
      end
      tx_have = tx_src_tcp ? (tcp_exp_q.size() > 0) : (arp_exp_q.size() > 0);
      checks++;
      assert (tx_have) else begin
        errors++;
        $display("net_tx carried a beat no source sent at %0t ns", $time);
      end
      if (tx_have) begin
        if (tx_src_tcp) tx_e = tcp_exp_q.pop_front();
        else tx_e = arp_exp_q.pop_front();
        compare("net_tx_data", net_tx_data, tx_e[63:0]);
        compare("net_tx_keep", net_tx_keep, tx_e[72:65]);
        compare("net_tx_last", net_tx_last, tx_e[64]);
      end
      compare("arp_tx_ready", arp_tx_ready, !tx_src_tcp);  // only the owner is taken
      compare("tcp_tx_ready", tcp_tx_ready, tx_src_tcp);
      tx_busy    = !net_tx_last;
      tx_cur_tcp = tx_src_tcp;
    end
  end

  initial begin
    #(total_beats() * 20 * 8);
    $display("watchdog expired, run took longer than %0d beats allow", total_beats());
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    int          base;
    int          exp_rxw, exp_rxp, exp_tcp, exp_drop, exp_txw;
    net_aresetn = 1'b0;
    set_ip_addr_data = '0;
    set_board_number_data = '0;
    {rx_valid, rx_data, rx_keep, rx_last} = '0;
    {arp_rx_ready, icmp_rx_ready, tcp_rx_ready, net_tx_ready} = '0;
    {arp_tx_valid, arp_tx_data, arp_tx_keep, arp_tx_last} = '0;
    {tcp_tx_valid, tcp_tx_data, tcp_tx_keep, tcp_tx_last} = '0;
    for (int i = 0; i < 32; i++) begin
      rx_pay[i] = {$random(seed), $random(seed)};
      tx_pay[i] = {$random(seed), $random(seed)};
    end
    repeat (5) @(posedge user_clk);
    #1 net_aresetn = 1'b1;
    err0 = errors;
    @(negedge user_clk);  // still holding reset values
    compare("local_ip_address", local_ip_address, 0);
    compare("local_mac_address", local_mac_address, 0);
    compare("default_gateway", default_gateway, 0);
    compare("rx_stall", rx_stall, 0);
    compare("rx_word_count", rx_word_count, 0);
    compare("tx_pkt_count", tx_pkt_count, 0);
    compare("net_tx_valid", net_tx_valid, 0);
    report("reset");
    // address config, byte swap then derive
    @(posedge user_clk);
    #1;
    set_ip_addr_data = 32'h0A0B0C0D;
    set_board_number_data = 8'h05;
    repeat (2) @(posedge user_clk);
    @(negedge user_clk);
    compare("local_ip_address", local_ip_address, 32'h0D0C0B0A);  // bytes reversed
    compare("local_mac_address", local_mac_address, 48'hEA9D02350A00);  // top byte e5 + 5
    compare("default_gateway", default_gateway, 32'h010C0B0A);  // top byte forced to 01
    report("address config");
    // stall, tcp header held with every sink blocked
    @(posedge user_clk);
    #1;
    {arp_rx_ready, icmp_rx_ready, tcp_rx_ready} = 3'b000;
    {rx_valid, rx_keep, rx_last} = {1'b1, 8'hFF, 1'b1};
    rx_data = {rx_pay[31][63:24], `NET_PROTO_TCP, `NET_ETH_IPV4};
    rx_exp_q.push_back({PROTO_TCP, rx_keep, rx_last, rx_data});
    repeat (3) @(posedge user_clk);
    @(negedge user_clk);
    compare("rx_stall", rx_stall, 0);  // limit reached, not yet exceeded
    @(posedge user_clk);
    @(negedge user_clk);
    compare("rx_stall", rx_stall, 1);
    @(posedge user_clk);
    #1;
    {arp_rx_ready, icmp_rx_ready, tcp_rx_ready} = 3'b111;
    wait_rx_xfer();
    rx_valid = 1'b0;
    repeat (2) @(posedge user_clk);
    @(negedge user_clk);
    compare("rx_stall", rx_stall, 1);  // sticky
    report("rx stall");
    // rx routing under random sink stalls
    @(posedge user_clk);
    #1;
    rand_ready = 1'b1;
    base = 0;
    for (int p = 0; p < N_RX; p++) begin
      send_rx(p, base);
      base += rx_len[p];
      report($sformatf("rx packet %0d", p));
    end
    compare("rx queue left", rx_exp_q.size(), 0);
    // tx merge, both sources contend
    @(posedge user_clk);
    #1;
    rand_ready = 1'b1;
    fork
      send_source(1'b0);
      send_source(1'b1);
    join
    compare("arp queue left", arp_exp_q.size(), 0);
    compare("tcp queue left", tcp_exp_q.size(), 0);
    report("tx merge");
    // totals from the tables, the stall packet is one tcp beat
    {exp_rxw, exp_rxp, exp_tcp, exp_drop, exp_txw} = {32'd1, 32'd1, 32'd1, 32'd0, 32'd0};
    for (int p = 0; p < N_RX; p++) begin
      exp_rxw += rx_len[p];
      exp_rxp++;
      if (rx_cls[p] == PROTO_TCP) exp_tcp++;
      if (rx_cls[p] == PROTO_DROP) exp_drop++;
    end
    foreach (tx_len[i]) exp_txw += tx_len[i];
    @(posedge user_clk);
    @(negedge user_clk);
    compare("rx_word_count", rx_word_count, exp_rxw);
    compare("rx_pkt_count", rx_pkt_count, exp_rxp);
    compare("tcp_rx_pkt_count", tcp_rx_pkt_count, exp_tcp);
    compare("drop_pkt_count", drop_pkt_count, exp_drop);
    compare("tx_word_count", tx_word_count, exp_txw);
    compare("tx_pkt_count", tx_pkt_count, N_TX);
    compare("rx_stall", rx_stall, 1);  // still set after all the traffic
    report("counters");
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- rtl/net_front.sv
/*
 * network front top level
 * address config, rx classification, tx merge and statistics
 */
`timescale 1ns/1ps

module net_front (
  input  logic                     user_clk,
  input  logic                     net_aresetn,
  // configuration
  input  net_proto_pkg::ip_addr_t  set_ip_addr_data,
  input  logic [7:0]               set_board_number_data,
  output net_proto_pkg::ip_addr_t  local_ip_address,
  output net_proto_pkg::mac_addr_t local_mac_address,
  output net_proto_pkg::ip_addr_t  default_gateway,
  // network rx in
  input  logic                     rx_valid,
  input  net_stream_pkg::beat_t    rx_data,
  input  net_stream_pkg::keep_t    rx_keep,
  input  logic                     rx_last,
  output logic                     rx_ready,
  // classified rx out, shared payload
  output net_stream_pkg::beat_t    rx_out_data,
  output net_stream_pkg::keep_t    rx_out_keep,
  output logic                     rx_out_last,
  output logic                     arp_rx_valid,
  input  logic                     arp_rx_ready,
  output logic                     icmp_rx_valid,
  input  logic                     icmp_rx_ready,
  output logic                     tcp_rx_valid,
  input  logic                     tcp_rx_ready,
  // tx sources
  input  logic                     arp_tx_valid,
  input  net_stream_pkg::beat_t    arp_tx_data,
  input  net_stream_pkg::keep_t    arp_tx_keep,
  input  logic                     arp_tx_last,
  output logic                     arp_tx_ready,
  input  logic                     tcp_tx_valid,
  input  net_stream_pkg::beat_t    tcp_tx_data,
  input  net_stream_pkg::keep_t    tcp_tx_keep,
  input  logic                     tcp_tx_last,
  output logic                     tcp_tx_ready,
  // merged network tx
  output logic                     net_tx_valid,
  output net_stream_pkg::beat_t    net_tx_data,
  output net_stream_pkg::keep_t    net_tx_keep,
  output logic                     net_tx_last,
  input  logic                     net_tx_ready,
  // statistics
  output net_stream_pkg::cnt_t     rx_word_count,
  output net_stream_pkg::cnt_t     rx_pkt_count,
  output net_stream_pkg::cnt_t     tx_word_count,
  output net_stream_pkg::cnt_t     tx_pkt_count,
  output net_stream_pkg::cnt_t     tcp_rx_pkt_count,
  output net_stream_pkg::cnt_t     drop_pkt_count,
  output logic                     rx_stall
);

  logic drop_pkt;  // classifier to stats only

  net_addr_config u_addr_config (
    .user_clk, .net_aresetn,
    .set_ip_addr_data, .set_board_number_data,
    .local_ip_address, .local_mac_address, .default_gateway
  );

  rx_classifier u_rx_classifier (
    .user_clk, .net_aresetn,
    .rx_valid, .rx_data, .rx_keep, .rx_last,
    .arp_rx_ready, .icmp_rx_ready, .tcp_rx_ready,
    .rx_ready, .rx_out_data, .rx_out_keep, .rx_out_last,
    .arp_rx_valid, .icmp_rx_valid, .tcp_rx_valid,
    .drop_pkt
  );

  tx_merger u_tx_merger (
    .user_clk, .net_aresetn,
    .arp_tx_valid, .arp_tx_data, .arp_tx_keep, .arp_tx_last,
    .tcp_tx_valid, .tcp_tx_data, .tcp_tx_keep, .tcp_tx_last,
    .net_tx_ready, .arp_tx_ready, .tcp_tx_ready,
    .net_tx_valid, .net_tx_data, .net_tx_keep, .net_tx_last
  );

  // stats taps the rx, tcp rx and merged tx handshakes
  net_stats u_net_stats (
    .user_clk, .net_aresetn,
    .rx_valid, .rx_ready, .rx_last,
    .net_tx_valid, .net_tx_ready, .net_tx_last,
    .tcp_rx_valid, .tcp_rx_ready, .rx_out_last, .drop_pkt,
    .rx_word_count, .rx_pkt_count, .tx_word_count, .tx_pkt_count,
    .tcp_rx_pkt_count, .drop_pkt_count, .rx_stall
  );

endmodule

//--- rtl/net_stats.sv
/*
 * traffic statistics
 * word and packet counters plus a sticky rx stall flag
 */
`timescale 1ns/1ps
`include "net_macros.svh"

module net_stats (
  input  logic                 user_clk,
  input  logic                 net_aresetn,
  input  logic                 rx_valid,
  input  logic                 rx_ready,
  input  logic                 rx_last,
  input  logic                 net_tx_valid,
  input  logic                 net_tx_ready,
  input  logic                 net_tx_last,
  input  logic                 tcp_rx_valid,
  input  logic                 tcp_rx_ready,
  input  logic                 rx_out_last,
  input  logic                 drop_pkt,
  output net_stream_pkg::cnt_t rx_word_count,
  output net_stream_pkg::cnt_t rx_pkt_count,
  output net_stream_pkg::cnt_t tx_word_count,
  output net_stream_pkg::cnt_t tx_pkt_count,
  output net_stream_pkg::cnt_t tcp_rx_pkt_count,
  output net_stream_pkg::cnt_t drop_pkt_count,
  output logic                 rx_stall
);
  import net_stream_pkg::*;

  logic [7:0] stall_cnt;  // consecutive back-pressured cycles
  logic       rx_xfer;
  logic       tx_xfer;
  logic       tcp_xfer;

  assign rx_xfer  = rx_valid && rx_ready;
  assign tx_xfer  = net_tx_valid && net_tx_ready;
  assign tcp_xfer = tcp_rx_valid && tcp_rx_ready;

  always_ff @(posedge user_clk) begin
    if (!net_aresetn) begin
      rx_word_count    <= '0;
      rx_pkt_count     <= '0;
      tx_word_count    <= '0;
      tx_pkt_count     <= '0;
      tcp_rx_pkt_count <= '0;
      drop_pkt_count   <= '0;
    end else begin
      if (rx_xfer) rx_word_count <= rx_word_count + cnt_t'(1);
      if (rx_xfer && rx_last) rx_pkt_count <= rx_pkt_count + cnt_t'(1);
      if (tx_xfer) tx_word_count <= tx_word_count + cnt_t'(1);
      if (tx_xfer && net_tx_last) tx_pkt_count <= tx_pkt_count + cnt_t'(1);
      if (tcp_xfer && rx_out_last) tcp_rx_pkt_count <= tcp_rx_pkt_count + cnt_t'(1);
      if (drop_pkt) drop_pkt_count <= drop_pkt_count + cnt_t'(1);
    end
  end

  always_ff @(posedge user_clk) begin
    if (!net_aresetn) begin
      stall_cnt <= '0;
      rx_stall  <= 1'b0;
    end else begin
      if (rx_ready) begin
        stall_cnt <= '0;
      end else if (rx_valid && stall_cnt != 8'hff) begin
        stall_cnt <= stall_cnt + 8'd1;  // saturate, flag is sticky anyway
      end
      if (stall_cnt > 8'(`NET_STALL_LIMIT)) rx_stall <= 1'b1;
    end
  end

  // a stall run past the limit raises the flag one cycle later
  a_stall_sets: assert property (@(posedge user_clk) disable iff (!net_aresetn)
    (rx_valid && !rx_ready) [*(`NET_STALL_LIMIT + 1)] |=> ##1 rx_stall);

endmodule

//--- rtl/tx_merger.sv
/*
 * transmit merger
 * round robin between arp and tcp, one whole packet per grant
 */
`timescale 1ns/1ps

module tx_merger (
  input  logic                  user_clk,
  input  logic                  net_aresetn,
  input  logic                  arp_tx_valid,
  input  net_stream_pkg::beat_t arp_tx_data,
  input  net_stream_pkg::keep_t arp_tx_keep,
  input  logic                  arp_tx_last,
  input  logic                  tcp_tx_valid,
  input  net_stream_pkg::beat_t tcp_tx_data,
  input  net_stream_pkg::keep_t tcp_tx_keep,
  input  logic                  tcp_tx_last,
  input  logic                  net_tx_ready,
  output logic                  arp_tx_ready,
  output logic                  tcp_tx_ready,
  output logic                  net_tx_valid,
  output net_stream_pkg::beat_t net_tx_data,
  output net_stream_pkg::keep_t net_tx_keep,
  output logic                  net_tx_last
);
  import net_stream_pkg::*;

  tx_grant_e grant;
  logic      last_tcp;  // tcp owned the previous packet
  logic      net_xfer;
  logic      pkt_done;

  // granted source passes straight through
  always_comb begin
    case (grant)
      GRANT_ARP: net_tx_valid = arp_tx_valid;
      GRANT_TCP: net_tx_valid = tcp_tx_valid;
      default:   net_tx_valid = 1'b0;  // idle cycle between packets
    endcase
  end

  assign net_tx_data  = (grant == GRANT_TCP) ? tcp_tx_data : arp_tx_data;
  assign net_tx_keep  = (grant == GRANT_TCP) ? tcp_tx_keep : arp_tx_keep;
  assign net_tx_last  = (grant == GRANT_TCP) ? tcp_tx_last : arp_tx_last;
  assign arp_tx_ready = (grant == GRANT_ARP) && net_tx_ready;
  assign tcp_tx_ready = (grant == GRANT_TCP) && net_tx_ready;

  assign net_xfer = net_tx_valid && net_tx_ready;
  assign pkt_done = net_xfer && net_tx_last;

  always_ff @(posedge user_clk) begin
    if (!net_aresetn) begin
      grant    <= GRANT_NONE;
      last_tcp <= 1'b0;
    end else begin
      case (grant)
        GRANT_NONE: begin
          if (arp_tx_valid && tcp_tx_valid) begin
            grant <= last_tcp ? GRANT_ARP : GRANT_TCP;  // alternate on contention
          end else if (arp_tx_valid) begin
            grant <= GRANT_ARP;
          end else if (tcp_tx_valid) begin
            grant <= GRANT_TCP;
          end
        end
        default: begin
          if (pkt_done) begin
            grant    <= GRANT_NONE;
            last_tcp <= (grant == GRANT_TCP);
          end
        end
      endcase
    end
  end

  // a back-pressured beat stays on net_tx until it is taken
  a_tx_hold: assert property (@(posedge user_clk) disable iff (!net_aresetn)
    net_tx_valid && !net_tx_ready |=>
      net_tx_valid && $stable({net_tx_data, net_tx_keep, net_tx_last}));

endmodule

//--- rtl/rx_classifier.sv
/*
 * receive classifier
 * decodes the first beat and steers the whole packet to arp, icmp or tcp,
 * or swallows it
 */
`timescale 1ns/1ps
`include "net_macros.svh"

module rx_classifier (
  input  logic                  user_clk,
  input  logic                  net_aresetn,
  input  logic                  rx_valid,
  input  net_stream_pkg::beat_t rx_data,
  input  net_stream_pkg::keep_t rx_keep,
  input  logic                  rx_last,
  input  logic                  arp_rx_ready,
  input  logic                  icmp_rx_ready,
  input  logic                  tcp_rx_ready,
  output logic                  rx_ready,
  output net_stream_pkg::beat_t rx_out_data,
  output net_stream_pkg::keep_t rx_out_keep,
  output logic                  rx_out_last,
  output logic                  arp_rx_valid,
  output logic                  icmp_rx_valid,
  output logic                  tcp_rx_valid,
  output logic                  drop_pkt
);
  import net_proto_pkg::*;

  logic       first_beat;  // next beat opens a packet
  proto_e     proto_q;     // class of the packet in flight
  proto_e     proto_hdr;   // class decoded from the current beat
  proto_e     proto_cur;
  ethertype_t ethertype;
  logic [7:0] ip_proto;
  logic       rx_xfer;

  assign ethertype = rx_data[15:0];
  assign ip_proto  = rx_data[23:16];

  always_comb begin
    proto_hdr = PROTO_DROP;
    if (ethertype == `NET_ETH_ARP) begin
      proto_hdr = PROTO_ARP;
    end else if (ethertype == `NET_ETH_IPV4) begin
      if (ip_proto == `NET_PROTO_ICMP) proto_hdr = PROTO_ICMP;
      else if (ip_proto == `NET_PROTO_TCP) proto_hdr = PROTO_TCP;
    end
  end

  assign proto_cur = first_beat ? proto_hdr : proto_q;  // header beat decides directly

  always_comb begin
    case (proto_cur)
      PROTO_ARP:  rx_ready = arp_rx_ready;
      PROTO_ICMP: rx_ready = icmp_rx_ready;
      PROTO_TCP:  rx_ready = tcp_rx_ready;
      default:    rx_ready = 1'b1;  // drops are sunk at full rate
    endcase
  end

  assign rx_xfer = rx_valid && rx_ready;

  // one shared payload, per class valids
  assign rx_out_data   = rx_data;
  assign rx_out_keep   = rx_keep;
  assign rx_out_last   = rx_last;
  assign arp_rx_valid  = rx_valid && (proto_cur == PROTO_ARP);
  assign icmp_rx_valid = rx_valid && (proto_cur == PROTO_ICMP);
  assign tcp_rx_valid  = rx_valid && (proto_cur == PROTO_TCP);
  assign drop_pkt      = rx_xfer && rx_last && (proto_cur == PROTO_DROP);

  always_ff @(posedge user_clk) begin
    if (!net_aresetn) begin
      first_beat <= 1'b1;
      proto_q    <= PROTO_DROP;
    end else if (rx_xfer) begin
      first_beat <= rx_last;
      if (first_beat) proto_q <= proto_hdr;  // latch class for the body
    end
  end

  // a beat held under back-pressure stays on the same output
  a_stall_same_output: assert property (@(posedge user_clk) disable iff (!net_aresetn)
    rx_valid && !rx_ready |=> $stable({arp_rx_valid, icmp_rx_valid, tcp_rx_valid}));

endmodule

//--- rtl/net_addr_config.sv
/*
 * address configuration
 * samples ip and board number, then derives local ip, mac and gateway
 */
`timescale 1ns/1ps
`include "net_macros.svh"

module net_addr_config (
  input  logic                     user_clk,
  input  logic                     net_aresetn,
  input  net_proto_pkg::ip_addr_t  set_ip_addr_data,
  input  logic [7:0]               set_board_number_data,
  output net_proto_pkg::ip_addr_t  local_ip_address,
  output net_proto_pkg::mac_addr_t local_mac_address,
  output net_proto_pkg::ip_addr_t  default_gateway
);
  import net_proto_pkg::*;

  localparam mac_addr_t mac_base = `NET_MAC_BASE;

  ip_addr_t   ip_q;     // byte swapped input
  logic [7:0] board_q;

  // first stage, sampled every cycle
  always_ff @(posedge user_clk) begin
    if (!net_aresetn) begin
      ip_q    <= `NET_IP_RESET;
      board_q <= '0;
    end else begin
      ip_q    <= {set_ip_addr_data[7:0], set_ip_addr_data[15:8],
                  set_ip_addr_data[23:16], set_ip_addr_data[31:24]};
      board_q <= set_board_number_data;
    end
  end

  // second stage distributes the derived values
  always_ff @(posedge user_clk) begin
    if (!net_aresetn) begin
      local_ip_address  <= '0;
      local_mac_address <= '0;
      default_gateway   <= '0;
    end else begin
      local_ip_address  <= ip_q;
      // board number offsets the top mac byte so boards stay unique
      local_mac_address <= {mac_base[47:40] + board_q, mac_base[39:0]};
      default_gateway   <= {8'h01, ip_q[23:0]};  // gateway sits at .1 of the subnet
    end
  end

endmodule

//--- rtl/net_proto_pkg.sv
/*
 * protocol types
 * receive class and the address and ethertype fields
 */
package net_proto_pkg;

  // class of a received packet, decided on its first beat
  typedef enum logic [1:0] {
    PROTO_ARP,
    PROTO_ICMP,
    PROTO_TCP,
    PROTO_DROP  // anything not handled here
  } proto_e;

  typedef logic [15:0] ethertype_t;

  // addresses are kept lsb first, as on the wire
  typedef logic [31:0] ip_addr_t;
  typedef logic [47:0] mac_addr_t;

endpackage

//--- rtl/net_stream_pkg.sv
/*
 * stream types
 * beat payload, byte enables, statistics counters and tx grant state
 */
`include "net_macros.svh"

package net_stream_pkg;

  typedef logic [`NET_DATA_W-1:0] beat_t;  // one 64 bit word
  typedef logic [`NET_KEEP_W-1:0] keep_t;  // byte enables
  typedef logic [`NET_CNT_W-1:0] cnt_t;

  // tx merge owner, held for a whole packet
  typedef enum logic [1:0] {
    GRANT_NONE,
    GRANT_ARP,
    GRANT_TCP
  } tx_grant_e;

endpackage

//--- rtl/net_macros.svh
/*
 * network front shared constants
 * widths, ethertype and IP protocol codes, reset values and base addresses
 */
`ifndef NET_MACROS_SVH
`define NET_MACROS_SVH

// stream widths
`define NET_DATA_W 64
`define NET_KEEP_W 8
`define NET_CNT_W 32

// header codes
`define NET_ETH_ARP  16'h0806
`define NET_ETH_IPV4 16'h0800
`define NET_PROTO_ICMP 8'd1
`define NET_PROTO_TCP  8'd6

// reset and base addresses, lsb first
`define NET_IP_RESET 32'hD1D4010B
`define NET_MAC_BASE 48'hE59D02350A00

// stalled cycles tolerated before rx_stall sets
`define NET_STALL_LIMIT 2

`endif
